//--- hw/sha256_seq_pkg.sv
package sha256_seq_pkg;

    // Sizes fixed by the SHA-256 standard
    localparam int WORD_W      = 32;  // Message and chaining word width
    localparam int BLOCK_WORDS = 16;  // Message words per 512-bit block
    localparam int NUM_ROUNDS  = 64;  // Compression rounds per block

    // Index widths derived from the sizes above
    localparam int ROUND_IDX_W = $clog2(NUM_ROUNDS);   // 6 bits, rounds 0..63
    localparam int WORD_IDX_W  = $clog2(BLOCK_WORDS);  // 4 bits, words 0..15

    // One message word or one working variable a..h
    typedef logic [WORD_W-1:0] word_t;

    // Round index, also drives the word read in the store
    typedef logic [ROUND_IDX_W-1:0] round_idx_t;

    // Index into the stored message words
    typedef logic [WORD_IDX_W-1:0] word_idx_t;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE,    // Waiting for start
        LOAD,    // Initial chaining state applied
        ROUNDS,  // 64 round cycles
        FINISH,  // Result latch cycle
        DONE     // Completion cycle
    } seq_state_e;

endpackage

//--- hw/sha256_block_store.sv
`timescale 1ns/1ps

module sha256_block_store
    import sha256_seq_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load_i,   // Capture strobe from the FSM
    input  round_idx_t round_i,  // Current round index
    input  word_t      w0_i,
    input  word_t      w1_i,
    input  word_t      w2_i,
    input  word_t      w3_i,
    input  word_t      w4_i,
    input  word_t      w5_i,
    input  word_t      w6_i,
    input  word_t      w7_i,
    input  word_t      w8_i,
    input  word_t      w9_i,
    input  word_t      w10_i,
    input  word_t      w11_i,
    input  word_t      w12_i,
    input  word_t      w13_i,
    input  word_t      w14_i,
    input  word_t      w15_i,
    input  word_t      hv_a_i,   // Chaining words a..h
    input  word_t      hv_b_i,
    input  word_t      hv_c_i,
    input  word_t      hv_d_i,
    input  word_t      hv_e_i,
    input  word_t      hv_f_i,
    input  word_t      hv_g_i,
    input  word_t      hv_h_i,
    output word_t      word_o,   // Stored word at the round index
    output word_t      hv_a_o,
    output word_t      hv_b_o,
    output word_t      hv_c_o,
    output word_t      hv_d_o,
    output word_t      hv_e_o,
    output word_t      hv_f_o,
    output word_t      hv_g_o,
    output word_t      hv_h_o
);

    word_t [BLOCK_WORDS-1:0] msg_in;  // Loose inputs gathered into one array
    word_t [BLOCK_WORDS-1:0] msg_q;   // Captured message block
    word_idx_t               rd_idx;  // Read pointer into msg_q

    assign msg_in[0]  = w0_i;
    assign msg_in[1]  = w1_i;
    assign msg_in[2]  = w2_i;
    assign msg_in[3]  = w3_i;
    assign msg_in[4]  = w4_i;
    assign msg_in[5]  = w5_i;
    assign msg_in[6]  = w6_i;
    assign msg_in[7]  = w7_i;
    assign msg_in[8]  = w8_i;
    assign msg_in[9]  = w9_i;
    assign msg_in[10] = w10_i;
    assign msg_in[11] = w11_i;
    assign msg_in[12] = w12_i;
    assign msg_in[13] = w13_i;
    assign msg_in[14] = w14_i;
    assign msg_in[15] = w15_i;

    // Message block, held between loads
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            msg_q <= '0;
        end else if (load_i) begin
            msg_q <= msg_in;
        end
    end

    // Chaining words a..h
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hv_a_o <= '0;
            hv_b_o <= '0;
            hv_c_o <= '0;
            hv_d_o <= '0;
            hv_e_o <= '0;
            hv_f_o <= '0;
            hv_g_o <= '0;
            hv_h_o <= '0;
        end else if (load_i) begin
            hv_a_o <= hv_a_i;
            hv_b_o <= hv_b_i;
            hv_c_o <= hv_c_i;
            hv_d_o <= hv_d_i;
            hv_e_o <= hv_e_i;
            hv_f_o <= hv_f_i;
            hv_g_o <= hv_g_i;
            hv_h_o <= hv_h_i;
        end
    end

    // Low index bits only; the phase split lives in the FSM
    assign rd_idx = round_i[WORD_IDX_W-1:0];
    assign word_o = msg_q[rd_idx];  // Unregistered read

    // Block contents only move on the edge where load_i is seen
    a_store_stable : assert property (
        @(posedge clk) disable iff (rst)
        !load_i |=> $stable(msg_q) &&
                    $stable({hv_a_o, hv_b_o, hv_c_o, hv_d_o,
                             hv_e_o, hv_f_o, hv_g_o, hv_h_o})
    ) else $error("block store changed without a load");

endmodule

//--- hw/sha256_round_fsm.sv
`timescale 1ns/1ps

module sha256_round_fsm
    import sha256_seq_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start_i,         // One-cycle start strobe
    output logic       load_o,          // Capture strobe for the block store
    output logic       busy_o,          // Run in progress
    output logic       init_sel_o,      // Initial-state select in the LOAD cycle
    output logic       round_valid_o,   // A round is being presented
    output round_idx_t round_o,         // Current round index
    output logic       word_valid_o,    // Stored word valid in rounds 0..15
    output logic       expand_sel_o,    // Schedule expansion in rounds 16..63
    output logic       result_latch_o,  // After round 63
    output logic       done_o           // One cycle after result latch
);

    localparam round_idx_t LAST_ROUND = round_idx_t'(NUM_ROUNDS - 1);
    localparam round_idx_t FIRST_EXP  = round_idx_t'(BLOCK_WORDS);

    seq_state_e state_q;
    seq_state_e state_d;
    round_idx_t cnt_q;       // Round counter
    logic       start_ok;    // Start accepted this edge
    logic       word_phase;  // Counter still inside the message words

    // Start only counts in IDLE and is ignored while busy
    assign start_ok = start_i && (state_q == IDLE);

    // Next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (start_ok) begin
                    state_d = LOAD;
                end
            end
            LOAD: begin
                state_d = ROUNDS;  // Single cycle
            end
            ROUNDS: begin
                if (cnt_q == LAST_ROUND) begin
                    state_d = FINISH;
                end
            end
            FINISH: begin
                state_d = DONE;
            end
            DONE: begin
                state_d = IDLE;  // New start accepted from here on
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Round counter
    // Cleared in LOAD so round 0 starts on the next edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (state_q == LOAD) begin
            cnt_q <= '0;
        end else if (state_q == ROUNDS) begin
            cnt_q <= cnt_q + 1'b1;  // Wraps to 0 after round 63
        end
    end

    assign word_phase = (cnt_q < FIRST_EXP);

    // Strobe decode from state and counter
    assign load_o         = start_ok;  // Store captures on the same edge
    assign busy_o         = (state_q != IDLE);
    assign init_sel_o     = (state_q == LOAD);
    assign round_valid_o  = (state_q == ROUNDS);
    assign round_o        = cnt_q;
    assign word_valid_o   = round_valid_o && word_phase;
    assign expand_sel_o   = round_valid_o && !word_phase;
    assign result_latch_o = (state_q == FINISH);
    assign done_o         = (state_q == DONE);

    // Completion never overlaps a round and comes two cycles after the last one
    a_done_not_round : assert property (
        @(posedge clk) disable iff (rst)
        done_o |-> !round_valid_o && $past(round_valid_o, 2) &&
                   ($past(round_o, 2) == LAST_ROUND)
    ) else $error("done_o high during a round or not after the last round");

    // Load only from idle and the run starts with the init cycle
    a_load_from_idle : assert property (
        @(posedge clk) disable iff (rst)
        load_o |-> !busy_o ##1 (busy_o && init_sel_o)
    ) else $error("load_o fired while busy or run did not start");

    // Result latch leads done by exactly one cycle
    a_latch_then_done : assert property (
        @(posedge clk) disable iff (rst)
        result_latch_o |=> done_o
    ) else $error("done_o did not follow result_latch_o");

endmodule

//--- hw/sha256_seq_top.sv
`timescale 1ns/1ps

module sha256_seq_top
    import sha256_seq_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start_i,         // One-cycle start strobe
    input  word_t      w0_i,            // Message words 0..15
    input  word_t      w1_i,
    input  word_t      w2_i,
    input  word_t      w3_i,
    input  word_t      w4_i,
    input  word_t      w5_i,
    input  word_t      w6_i,
    input  word_t      w7_i,
    input  word_t      w8_i,
    input  word_t      w9_i,
    input  word_t      w10_i,
    input  word_t      w11_i,
    input  word_t      w12_i,
    input  word_t      w13_i,
    input  word_t      w14_i,
    input  word_t      w15_i,
    input  word_t      hv_a_i,          // Chaining words a..h
    input  word_t      hv_b_i,
    input  word_t      hv_c_i,
    input  word_t      hv_d_i,
    input  word_t      hv_e_i,
    input  word_t      hv_f_i,
    input  word_t      hv_g_i,
    input  word_t      hv_h_i,
    output logic       busy_o,
    output logic       init_sel_o,
    output logic       round_valid_o,
    output round_idx_t round_o,
    output logic       word_valid_o,
    output word_t      word_o,          // Valid only with word_valid_o
    output logic       expand_sel_o,
    output logic       result_latch_o,
    output logic       done_o,
    output word_t      hv_a_o,
    output word_t      hv_b_o,
    output word_t      hv_c_o,
    output word_t      hv_d_o,
    output word_t      hv_e_o,
    output word_t      hv_f_o,
    output word_t      hv_g_o,
    output word_t      hv_h_o
);

    logic load_w;  // FSM to store capture strobe

    sha256_round_fsm sha256_round_fsm_inst (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start_i),
        .load_o         (load_w),
        .busy_o         (busy_o),
        .init_sel_o     (init_sel_o),
        .round_valid_o  (round_valid_o),
        .round_o        (round_o),          // Also the store read index
        .word_valid_o   (word_valid_o),
        .expand_sel_o   (expand_sel_o),
        .result_latch_o (result_latch_o),
        .done_o         (done_o)
    );

    sha256_block_store sha256_block_store_inst (
        .clk     (clk),
        .rst     (rst),
        .load_i  (load_w),
        .round_i (round_o),
        .w0_i    (w0_i),
        .w1_i    (w1_i),
        .w2_i    (w2_i),
        .w3_i    (w3_i),
        .w4_i    (w4_i),
        .w5_i    (w5_i),
        .w6_i    (w6_i),
        .w7_i    (w7_i),
        .w8_i    (w8_i),
        .w9_i    (w9_i),
        .w10_i   (w10_i),
        .w11_i   (w11_i),
        .w12_i   (w12_i),
        .w13_i   (w13_i),
        .w14_i   (w14_i),
        .w15_i   (w15_i),
        .hv_a_i  (hv_a_i),
        .hv_b_i  (hv_b_i),
        .hv_c_i  (hv_c_i),
        .hv_d_i  (hv_d_i),
        .hv_e_i  (hv_e_i),
        .hv_f_i  (hv_f_i),
        .hv_g_i  (hv_g_i),
        .hv_h_i  (hv_h_i),
        .word_o  (word_o),
        .hv_a_o  (hv_a_o),
        .hv_b_o  (hv_b_o),
        .hv_c_o  (hv_c_o),
        .hv_d_o  (hv_d_o),
        .hv_e_o  (hv_e_o),
        .hv_f_o  (hv_f_o),
        .hv_g_o  (hv_g_o),
        .hv_h_o  (hv_h_o)
    );

endmodule

//--- verif/sha256_seq_tb_cases.svh
`ifndef SHA256_SEQ_TB_CASES_SVH
`define SHA256_SEQ_TB_CASES_SVH

// Cycle numbers counted from the edge where a start is accepted
localparam int INIT_CYC   = 0;               // LOAD cycle
localparam int LATCH_CYC  = NUM_ROUNDS + 1;  // FINISH cycle
localparam int DONE_CYC   = NUM_ROUNDS + 2;  // DONE cycle
localparam int RUN_CYCLES = NUM_ROUNDS + 3;  // First idle cycle

localparam int NUM_CASES = 6;
localparam int MAX_GAP   = 9;  // Largest entry of case_gap

// One row per block
// case_dup     : extra start strobe inside the run
// case_dup_cyc : edge where that strobe is driven, seen one edge later
// case_gap     : idle cycles before the next accepted start, at least 1
string case_name [NUM_CASES] = '{
    "basic_block",
    "held_start",
    "start_in_words",
    "start_in_expand",
    "start_at_finish",
    "long_gap"
};
bit case_dup [NUM_CASES] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
int case_dup_cyc [NUM_CASES] = '{0, 0, 8, 40, 65, 0};
int case_gap [NUM_CASES] = '{1, 2, 1, 5, 1, 9};

`endif

//--- verif/sha256_seq_tb.sv
`timescale 1ns/1ps

module sha256_seq_tb
    import sha256_seq_pkg::*;
;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;

    `include "sha256_seq_tb_cases.svh"

    // Budget per case: one run, the largest gap and some slack
    localparam int WATCHDOG_CYC = RESET_CYCLES + NUM_CASES * (RUN_CYCLES + MAX_GAP + 20);

    logic       clk = 1'b0;
    logic       rst;
    logic       start_i;
    word_t      w_in [BLOCK_WORDS];  // Message word inputs
    word_t      hv_in [8];           // Chaining inputs a..h
    logic       busy_o;
    logic       init_sel_o;
    logic       round_valid_o;
    round_idx_t round_o;
    logic       word_valid_o;
    word_t      word_o;
    logic       expand_sel_o;
    logic       result_latch_o;
    logic       done_o;
    word_t      hv_out [8];

    word_t pend_msg [BLOCK_WORDS];  // Block queued for the next start
    word_t pend_hv [8];
    word_t exp_msg [BLOCK_WORDS];   // Block of the last accepted start
    word_t exp_hv [8];
    int    seed = 89;
    int    errors = 0;
    int    checks = 0;
    string cur_case;

    always #(CLK_PERIOD / 2) clk = ~clk;

    sha256_seq_top sha256_seq_top_inst (
        .clk(clk), .rst(rst), .start_i(start_i),
        .w0_i(w_in[0]), .w1_i(w_in[1]), .w2_i(w_in[2]), .w3_i(w_in[3]),
        .w4_i(w_in[4]), .w5_i(w_in[5]), .w6_i(w_in[6]), .w7_i(w_in[7]),
        .w8_i(w_in[8]), .w9_i(w_in[9]), .w10_i(w_in[10]), .w11_i(w_in[11]),
        .w12_i(w_in[12]), .w13_i(w_in[13]), .w14_i(w_in[14]), .w15_i(w_in[15]),
        .hv_a_i(hv_in[0]), .hv_b_i(hv_in[1]), .hv_c_i(hv_in[2]), .hv_d_i(hv_in[3]),
        .hv_e_i(hv_in[4]), .hv_f_i(hv_in[5]), .hv_g_i(hv_in[6]), .hv_h_i(hv_in[7]),
        .busy_o(busy_o), .init_sel_o(init_sel_o), .round_valid_o(round_valid_o),
        .round_o(round_o), .word_valid_o(word_valid_o), .word_o(word_o),
        .expand_sel_o(expand_sel_o), .result_latch_o(result_latch_o), .done_o(done_o),
        .hv_a_o(hv_out[0]), .hv_b_o(hv_out[1]), .hv_c_o(hv_out[2]), .hv_d_o(hv_out[3]),
        .hv_e_o(hv_out[4]), .hv_f_o(hv_out[5]), .hv_g_o(hv_out[6]), .hv_h_o(hv_out[7])
    );

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", cur_case, what, exp, act);
        end
    endtask

    // New random block on the inputs; keep marks it as the next expected block
    task automatic drive_words(input bit keep);
        word_t v;
        int    i;
        for (i = 0; i < BLOCK_WORDS; i++) begin
            v = $random(seed);
            w_in[i] <= v;
            if (keep) pend_msg[i] = v;
        end
        for (i = 0; i < 8; i++) begin
            v = $random(seed);
            hv_in[i] <= v;
            if (keep) pend_hv[i] = v;
        end
    endtask

    // Expected outputs of cycle n after the start edge
    task automatic check_cycle(input int n);
        bit in_round;
        int r;
        int i;
        in_round = (n >= 1) && (n <= NUM_ROUNDS);
        r = n - 1;  // Round index inside the run
        check_value("busy_o", n < RUN_CYCLES, busy_o);
        check_value("init_sel_o", n == INIT_CYC, init_sel_o);
        check_value("round_valid_o", in_round, round_valid_o);
        check_value("word_valid_o", in_round && r < BLOCK_WORDS, word_valid_o);
        check_value("expand_sel_o", in_round && r >= BLOCK_WORDS, expand_sel_o);
        check_value("result_latch_o", n == LATCH_CYC, result_latch_o);
        check_value("done_o", n == DONE_CYC, done_o);
        if (in_round) check_value("round_o", r, round_o);
        if (in_round && r < BLOCK_WORDS) check_value("word_o", exp_msg[r], word_o);
        for (i = 0; i < 8; i++) begin
            check_value("hv_out", exp_hv[i], hv_out[i]);  // Chaining hold
        end
        if (word_valid_o && expand_sel_o) begin
            errors++;
            $display("ERROR: %s word and expand selects both high in cycle %0d", cur_case, n);
        end
    endtask

    initial begin
        int c;
        int n;
        int last_cyc;
        int i;
        rst     = 1'b1;
        start_i = 1'b0;
        for (i = 0; i < BLOCK_WORDS; i++) w_in[i] = '0;
        for (i = 0; i < 8; i++) hv_in[i] = '0;
        cur_case = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("busy_o", 0, busy_o);  // Reset state
        check_value("init_sel_o", 0, init_sel_o);
        check_value("round_valid_o", 0, round_valid_o);
        check_value("word_valid_o", 0, word_valid_o);
        check_value("expand_sel_o", 0, expand_sel_o);
        check_value("result_latch_o", 0, result_latch_o);
        check_value("done_o", 0, done_o);
        check_value("round_o", 0, round_o);
        check_value("word_o", 0, word_o);  // Store cleared
        for (i = 0; i < 8; i++) check_value("hv_out", 0, hv_out[i]);
        @(posedge clk);
        drive_words(1'b1);
        start_i <= 1'b1;
        for (c = 0; c < NUM_CASES; c++) begin
            @(posedge clk);  // Edge 0, start accepted here
            cur_case = case_name[c];
            exp_msg  = pend_msg;
            exp_hv   = pend_hv;
            drive_words(1'b0);  // Inputs move away after capture
            start_i <= case_dup[c] && case_dup_cyc[c] == 0;  // Held into LOAD
            last_cyc = RUN_CYCLES - 1 + case_gap[c];
            for (n = 0; n <= last_cyc; n++) begin
                @(negedge clk);
                check_cycle(n);
                if (n < last_cyc) begin
                    @(posedge clk);  // Edge n+1
                    start_i <= 1'b0;
                    if (case_dup[c] && n + 1 == case_dup_cyc[c]) begin
                        drive_words(1'b0);  // Must be ignored
                        start_i <= 1'b1;
                    end
                    if (c + 1 < NUM_CASES && n + 1 == last_cyc) begin
                        drive_words(1'b1);  // Seen on the next edge
                        start_i <= 1'b1;
                    end
                end
            end
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        errors++;
        $display("ERROR: run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+verif
hw/sha256_seq_pkg.sv
hw/sha256_block_store.sv
hw/sha256_round_fsm.sv
hw/sha256_seq_top.sv
verif/sha256_seq_tb.sv

//--- Bender.yml
package:
  name: sha256_seq

sources:
  - files:
      - hw/sha256_seq_pkg.sv
      - hw/sha256_block_store.sv
      - hw/sha256_round_fsm.sv
      - hw/sha256_seq_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/sha256_seq_tb.sv
